//--- clink_rx_pkg.sv
/* Shared types and decode for the chiplet link receiver.
   Beats are 32 bits wide and carry 4 bytes. A packet holds at most 8 data bytes,
   so longer lengths are clamped to two data beats. */
package clink_rx_pkg;

   //######################################
   // Widths
   //######################################
   localparam int CW         = 32;         // Command word
   localparam int AW         = 32;         // Address
   localparam int DW         = 64;         // Data payload
   localparam int IOW        = 32;         // Pad beat
   localparam int BEAT_BYTES = 4;          // Bytes per beat
   localparam int CRDT_W     = 16;         // Credit counters
   localparam int HDR_BEATS  = 3;          // cmd + dst + src
   localparam int DATA_BEATS = DW / IOW;   // Max data beats

   // Opcodes, reduced set
   localparam logic [3:0] OP_REQ_RD  = 4'd1;   // No data
   localparam logic [3:0] OP_REQ_WR  = 4'd2;   // With data
   localparam logic [3:0] OP_RESP_RD = 4'd3;   // With data
   localparam logic [3:0] OP_RESP_WR = 4'd4;   // No data
   localparam logic [3:0] OP_LINK    = 4'd15;  // Command word only

   // Link credit codes, carried in the length field
   localparam logic [7:0] CRDT_CODE_REQ  = 8'h01;
   localparam logic [7:0] CRDT_CODE_RESP = 8'h11;

   //######################################
   // Types
   //######################################
   typedef enum logic [1:0] {CLS_NONE, CLS_REQ, CLS_RESP, CLS_LINK} cmd_class_e;

   typedef logic [IOW-1:0] beat_t;
   typedef logic [2:0]     bcnt_t;       // Beat count, up to 5

   // Command word fields; ext holds the credit value on link packets
   typedef struct packed {
      logic [15:0] ext;
      logic [7:0]  len;                  // Length or credit code
      logic        rsvd;
      logic [2:0]  size;
      logic [3:0]  opcode;
   } cmd_t;

   typedef struct packed {
      logic [CW-1:0] cmd;
      logic [AW-1:0] dstaddr;
      logic [AW-1:0] srcaddr;
      logic [DW-1:0] data;
   } umi_pkt_t;

   typedef struct packed {
      logic        valid;
      logic [7:0]  code;
      logic [15:0] value;
   } link_crdt_t;

   //######################################
   // Decode
   //######################################
   function automatic cmd_class_e pkt_class(input logic [3:0] opcode);
      case (opcode)
         OP_REQ_RD, OP_REQ_WR:   return CLS_REQ;
         OP_RESP_RD, OP_RESP_WR: return CLS_RESP;
         OP_LINK:                return CLS_LINK;
         default:                return CLS_NONE;  // Dropped by framer
      endcase
   endfunction

   function automatic bcnt_t pkt_beats(input cmd_t cmd);
      logic [15:0] nbytes;
      logic [15:0] dbeats;
      nbytes = ({8'h00, cmd.len} + 16'd1) << cmd.size;
      dbeats = (nbytes + 16'(BEAT_BYTES - 1)) >> $clog2(BEAT_BYTES);  // Round up
      if (dbeats > 16'(DATA_BEATS))
         dbeats = 16'(DATA_BEATS);
      case (cmd.opcode)
         OP_LINK:                return bcnt_t'(1);
         OP_REQ_RD, OP_RESP_WR:  return bcnt_t'(HDR_BEATS);
         OP_REQ_WR, OP_RESP_RD:  return bcnt_t'(HDR_BEATS) + dbeats[2:0];
         default:                return bcnt_t'(1);
      endcase
   endfunction

endpackage

//--- clink_rx_framer.sv
/* Pad sampling and packet framing. Rising edge only, no back-pressure:
   the sender keeps within the credits. Unknown opcodes are taken as
   single-beat packets and dropped. */
`timescale 1ns/100ps
module clink_rx_framer
   (input  logic                ioclk,
    input  logic                ionreset,
    input  logic                rx_valid,
    input  clink_rx_pkg::beat_t rx_data,
    output logic                wr_req,
    output logic                wr_resp,
    output logic                wr_link,
    output clink_rx_pkg::beat_t wr_beat
   );
   import clink_rx_pkg::*;

   logic       rx_valid_q;   // Sampled valid
   beat_t      rx_data_q;    // Sampled beat
   bcnt_t      rem_q;        // Beats left after current one
   cmd_class_e cls_q;        // Class latched at packet start
   logic       sop;
   cmd_t       rx_cmd;
   cmd_class_e dec_cls;
   bcnt_t      dec_beats;
   cmd_class_e cur_cls;

   //######################################
   // Input sampling
   //######################################
   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
         rx_valid_q <= 1'b0;
      else
         rx_valid_q <= rx_valid;
   end

   always_ff @(posedge ioclk)
   begin
      rx_data_q <= rx_data;   // Payload only
   end

   //######################################
   // Packet boundary tracking
   //######################################
   assign sop       = (rem_q == '0);          // Next valid beat is a command
   assign rx_cmd    = cmd_t'(rx_data_q);
   assign dec_cls   = pkt_class(rx_cmd.opcode);
   assign dec_beats = pkt_beats(rx_cmd);

   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
      begin
         rem_q <= '0;
         cls_q <= CLS_NONE;
      end
      else if (rx_valid_q)
      begin
         if (sop)
         begin
            rem_q <= dec_beats - bcnt_t'(1);
            cls_q <= dec_cls;
         end
         else
            rem_q <= rem_q - bcnt_t'(1);   // Gaps in valid just pause the count
      end
   end

   // Command beat steers itself, the rest follow the latched class
   assign cur_cls = sop ? dec_cls : cls_q;

   //######################################
   // Queue write steering
   //######################################
   assign wr_req  = rx_valid_q & (cur_cls == CLS_REQ);
   assign wr_resp = rx_valid_q & (cur_cls == CLS_RESP);
   assign wr_link = rx_valid_q & (cur_cls == CLS_LINK);
   assign wr_beat = rx_data_q;   // Shared by all three queues

endmodule

//--- clink_rx_fifo.sv
/* Synchronous beat queue. Head is visible combinationally on rd_beat.
   Writes when full and reads when empty are ignored. */
`timescale 1ns/100ps
module clink_rx_fifo
   #(parameter int DEPTH = 4)
   (input  logic                ioclk,
    input  logic                ionreset,
    input  logic                wr_en,
    input  logic                rd_en,
    input  clink_rx_pkg::beat_t wr_beat,
    output clink_rx_pkg::beat_t rd_beat,
    output logic                empty,
    output logic                full
   );
   import clink_rx_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   beat_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;    // Occupancy
   logic             wr_ok;
   logic             rd_ok;

   assign wr_ok = wr_en & ~full;
   assign rd_ok = rd_en & ~empty;

   always_ff @(posedge ioclk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= wr_beat;
   end

   // Pointers wrap at DEPTH, need not be a power of two
   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         if (rd_ok)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         count <= count + CNT_W'(wr_ok) - CNT_W'(rd_ok);
      end
   end

   assign rd_beat = mem[rd_ptr];
   assign empty   = (count == '0);
   assign full    = (count == CNT_W'(DEPTH));

endmodule

//--- clink_rx_assembler.sv
/* Rebuilds packets from the class queues. Priority link, response, request,
   held per packet. The last beat of a packet is only read once its output
   holding register is free, so one packet is held and one is in build. */
`timescale 1ns/100ps
module clink_rx_assembler
   (input  logic                     ioclk,
    input  logic                     ionreset,
    input  clink_rx_pkg::beat_t      head_req,
    input  clink_rx_pkg::beat_t      head_resp,
    input  clink_rx_pkg::beat_t      head_link,
    input  logic                     empty_req,
    input  logic                     empty_resp,
    input  logic                     empty_link,
    output logic                     rd_req,
    output logic                     rd_resp,
    output logic                     rd_link,
    output logic                     req_pop,
    output logic                     resp_pop,
    output clink_rx_pkg::link_crdt_t link_crdt,
    output clink_rx_pkg::umi_pkt_t   req_pkt,
    output clink_rx_pkg::umi_pkt_t   resp_pkt,
    output logic                     req_valid,
    output logic                     resp_valid,
    input  logic                     req_ready,
    input  logic                     resp_ready
   );
   import clink_rx_pkg::*;

   cmd_class_e sel_q;       // Queue owned by packet in build
   cmd_class_e cur_sel;
   bcnt_t      idx_q;       // Beat index in packet
   bcnt_t      nbeats_q;    // Beat count latched from command
   bcnt_t      cur_beats;
   beat_t      cur_head;
   cmd_t       cur_cmd;
   logic       cur_empty;
   logic       can_last;    // Destination free for a finished packet
   logic       last;
   logic       rd_go;
   umi_pkt_t   pkt_q;       // Packet under construction
   umi_pkt_t   pkt_next;

   //######################################
   // Queue selection
   //######################################
   always_comb
   begin
      if (idx_q != '0)
         cur_sel = sel_q;               // Stay on queue mid-packet
      else if (!empty_link)
         cur_sel = CLS_LINK;
      else if (!empty_resp)
         cur_sel = CLS_RESP;
      else if (!empty_req)
         cur_sel = CLS_REQ;
      else
         cur_sel = CLS_NONE;
   end

   always_comb
   begin
      case (cur_sel)
         CLS_RESP: cur_head = head_resp;
         CLS_LINK: cur_head = head_link;
         default:  cur_head = head_req;
      endcase
      case (cur_sel)
         CLS_REQ:  cur_empty = empty_req;
         CLS_RESP: cur_empty = empty_resp;
         CLS_LINK: cur_empty = empty_link;
         default:  cur_empty = 1'b1;
      endcase
      case (cur_sel)
         CLS_REQ:  can_last = ~req_valid | req_ready;    // Slot frees this cycle
         CLS_RESP: can_last = ~resp_valid | resp_ready;
         CLS_LINK: can_last = 1'b1;                      // Never held
         default:  can_last = 1'b0;
      endcase
   end

   assign cur_cmd   = cmd_t'(cur_head);
   assign cur_beats = (idx_q == '0) ? pkt_beats(cur_cmd) : nbeats_q;
   assign last      = (idx_q + bcnt_t'(1) == cur_beats);
   assign rd_go     = ~cur_empty & (~last | can_last);   // Stall before last beat

   assign rd_req   = rd_go & (cur_sel == CLS_REQ);
   assign rd_resp  = rd_go & (cur_sel == CLS_RESP);
   assign rd_link  = rd_go & (cur_sel == CLS_LINK);
   assign req_pop  = rd_req;    // One credit per drained beat
   assign resp_pop = rd_resp;

   //######################################
   // Packet build
   //######################################
   always_comb
   begin
      pkt_next = pkt_q;
      case (idx_q)
         3'd0:
         begin
            pkt_next      = '0;           // Clears data for no-data packets
            pkt_next.cmd  = cur_head;
         end
         3'd1:    pkt_next.dstaddr        = cur_head;
         3'd2:    pkt_next.srcaddr        = cur_head;
         3'd3:    pkt_next.data[IOW-1:0]  = cur_head;
         default: pkt_next.data[DW-1:IOW] = cur_head;
      endcase
   end

   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
      begin
         idx_q    <= '0;
         nbeats_q <= '0;
         sel_q    <= CLS_NONE;
      end
      else if (rd_go)
      begin
         idx_q <= last ? '0 : idx_q + bcnt_t'(1);
         sel_q <= cur_sel;
         if (idx_q == '0)
            nbeats_q <= cur_beats;
      end
   end

   always_ff @(posedge ioclk)
   begin
      if (rd_go)
         pkt_q <= pkt_next;
   end

   //######################################
   // Output holding registers
   //######################################
   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
      begin
         req_valid  <= 1'b0;
         resp_valid <= 1'b0;
      end
      else
      begin
         if (rd_req & last)
            req_valid <= 1'b1;
         else if (req_ready)
            req_valid <= 1'b0;
         if (rd_resp & last)
            resp_valid <= 1'b1;
         else if (resp_ready)
            resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge ioclk)
   begin
      if (rd_req & last)
         req_pkt <= pkt_next;
      if (rd_resp & last)
         resp_pkt <= pkt_next;
   end

   // Link packets end here as a one-cycle credit pulse
   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
         link_crdt <= '0;
      else
      begin
         link_crdt.valid <= rd_link & last;
         if (rd_link & last)
         begin
            link_crdt.code  <= cur_cmd.len;
            link_crdt.value <= cur_cmd.ext;
         end
      end
   end

endmodule

//--- clink_rx_credits.sv
/* Local and remote credit tracking. Local counters load their start value
   while csr_en is low. Remote values are taken only from the two known codes. */
`timescale 1ns/100ps
module clink_rx_credits
   (input  logic                            ioclk,
    input  logic                            ionreset,
    input  logic                            csr_en,
    input  logic [clink_rx_pkg::CRDT_W-1:0] csr_crdt_req_init,
    input  logic [clink_rx_pkg::CRDT_W-1:0] csr_crdt_resp_init,
    input  logic                            req_pop,
    input  logic                            resp_pop,
    input  clink_rx_pkg::link_crdt_t        link_crdt,
    output logic [clink_rx_pkg::CRDT_W-1:0] loc_crdt_req,
    output logic [clink_rx_pkg::CRDT_W-1:0] loc_crdt_resp,
    output logic [clink_rx_pkg::CRDT_W-1:0] rmt_crdt_req,
    output logic [clink_rx_pkg::CRDT_W-1:0] rmt_crdt_resp
   );
   import clink_rx_pkg::*;

   //######################################
   // Local credits, one per drained beat
   //######################################
   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
      begin
         loc_crdt_req  <= '0;
         loc_crdt_resp <= '0;
      end
      else if (!csr_en)
      begin
         loc_crdt_req  <= csr_crdt_req_init;    // Link disabled
         loc_crdt_resp <= csr_crdt_resp_init;
      end
      else
      begin
         if (req_pop)
            loc_crdt_req  <= loc_crdt_req + CRDT_W'(1);
         if (resp_pop)
            loc_crdt_resp <= loc_crdt_resp + CRDT_W'(1);
      end
   end

   //######################################
   // Remote credits from link packets
   //######################################
   always_ff @(posedge ioclk or negedge ionreset)
   begin
      if (!ionreset)
      begin
         rmt_crdt_req  <= '0;
         rmt_crdt_resp <= '0;
      end
      else if (link_crdt.valid)
      begin
         if (link_crdt.code == CRDT_CODE_REQ)
            rmt_crdt_req  <= link_crdt.value;
         if (link_crdt.code == CRDT_CODE_RESP)
            rmt_crdt_resp <= link_crdt.value;   // Other codes fall through
      end
   end

endmodule

//--- clink_rx_top.sv
/* Chiplet link receive path. SDR pad bus, 32 bits per beat.
   Queue depths must cover the credits granted to the sender. */
`timescale 1ns/100ps
module clink_rx_top
   #(parameter int REQ_DEPTH  = 64,
     parameter int RESP_DEPTH = 64,
     parameter int LINK_DEPTH = 4)
   (input  logic                            ioclk,
    input  logic                            ionreset,
    input  logic                            csr_en,
    input  logic [clink_rx_pkg::CRDT_W-1:0] csr_crdt_req_init,
    input  logic [clink_rx_pkg::CRDT_W-1:0] csr_crdt_resp_init,
    input  logic                            rx_valid,
    input  clink_rx_pkg::beat_t             rx_data,
    output clink_rx_pkg::umi_pkt_t          req_pkt,
    output logic                            req_valid,
    input  logic                            req_ready,
    output clink_rx_pkg::umi_pkt_t          resp_pkt,
    output logic                            resp_valid,
    input  logic                            resp_ready,
    output logic [clink_rx_pkg::CRDT_W-1:0] loc_crdt_req,
    output logic [clink_rx_pkg::CRDT_W-1:0] loc_crdt_resp,
    output logic [clink_rx_pkg::CRDT_W-1:0] rmt_crdt_req,
    output logic [clink_rx_pkg::CRDT_W-1:0] rmt_crdt_resp
   );
   import clink_rx_pkg::*;

   beat_t      wr_beat;                // Framer to all queues
   beat_t      head_req, head_resp, head_link;
   logic       wr_req, wr_resp, wr_link;
   logic       rd_req, rd_resp, rd_link;
   logic       empty_req, empty_resp, empty_link;
   logic       req_pop, resp_pop;
   link_crdt_t link_crdt;

   //######################################
   // Framing
   //######################################
   clink_rx_framer framer_i
      (.ioclk, .ionreset, .rx_valid, .rx_data,
       .wr_req, .wr_resp, .wr_link, .wr_beat);

   //######################################
   // Class queues
   //######################################
   clink_rx_fifo #(.DEPTH(REQ_DEPTH)) req_fifo_i
      (.ioclk, .ionreset, .wr_en(wr_req), .rd_en(rd_req), .wr_beat,
       .rd_beat(head_req), .empty(empty_req), .full());

   clink_rx_fifo #(.DEPTH(RESP_DEPTH)) resp_fifo_i
      (.ioclk, .ionreset, .wr_en(wr_resp), .rd_en(rd_resp), .wr_beat,
       .rd_beat(head_resp), .empty(empty_resp), .full());

   clink_rx_fifo #(.DEPTH(LINK_DEPTH)) link_fifo_i   // Link traffic has no credits
      (.ioclk, .ionreset, .wr_en(wr_link), .rd_en(rd_link), .wr_beat,
       .rd_beat(head_link), .empty(empty_link), .full());

   //######################################
   // Reassembly and credits
   //######################################
   clink_rx_assembler assembler_i
      (.ioclk, .ionreset,
       .head_req, .head_resp, .head_link,
       .empty_req, .empty_resp, .empty_link,
       .rd_req, .rd_resp, .rd_link,
       .req_pop, .resp_pop, .link_crdt,
       .req_pkt, .resp_pkt, .req_valid, .resp_valid,
       .req_ready, .resp_ready);

   clink_rx_credits credits_i
      (.ioclk, .ionreset, .csr_en, .csr_crdt_req_init, .csr_crdt_resp_init,
       .req_pop, .resp_pop, .link_crdt,
       .loc_crdt_req, .loc_crdt_resp, .rmt_crdt_req, .rmt_crdt_resp);

endmodule

//--- clink_rx_properties.sv
/* Protocol checks for the receiver. Bound once per queue for overflow
   and underflow, and once per output port for the valid/ready hold rule.
   Unused inputs of each binding are tied off. */
`timescale 1ns/100ps
module clink_rx_properties
   (input logic                   ioclk,
    input logic                   ionreset,
    input logic                   wr_en,
    input logic                   rd_en,
    input logic                   full,
    input logic                   empty,
    input logic                   valid,
    input logic                   ready,
    input clink_rx_pkg::umi_pkt_t pkt
   );

   // Sender overran its credits
   no_overflow: assert property (@(posedge ioclk) disable iff (!ionreset)
      !(wr_en && full))
      else $error("Beat written into a full queue");

   no_underflow: assert property (@(posedge ioclk) disable iff (!ionreset)
      !(rd_en && empty))
      else $error("Beat read from an empty queue");

   // Held packet stays until taken
   hold_until_ready: assert property (@(posedge ioclk) disable iff (!ionreset)
      (valid && !ready) |=> (valid && $stable(pkt)))
      else $error("Output packet dropped or changed before ready");

endmodule

bind clink_rx_fifo clink_rx_properties fifo_props_i
   (.ioclk, .ionreset, .wr_en, .rd_en, .full, .empty,
    .valid(1'b0), .ready(1'b1), .pkt('0));

bind clink_rx_top clink_rx_properties req_props_i
   (.ioclk, .ionreset, .wr_en(1'b0), .rd_en(1'b0), .full(1'b0), .empty(1'b0),
    .valid(req_valid), .ready(req_ready), .pkt(req_pkt));

bind clink_rx_top clink_rx_properties resp_props_i
   (.ioclk, .ionreset, .wr_en(1'b0), .rd_en(1'b0), .full(1'b0), .empty(1'b0),
    .valid(resp_valid), .ready(resp_ready), .pkt(resp_pkt));

//--- tb_clink_rx.sv
/* Directed testbench for the chiplet link receiver. Data packets carry
   8 data bytes (size 3, length 0). Link packets carry the credit code
   in bits 15..8 and the value in bits 31..16. */
`timescale 1ns/100ps
module tb_clink_rx;
   import clink_rx_pkg::*;

   localparam int CYCLE_LIMIT = 4000;   // Tests need a few hundred cycles
   localparam int WAIT_LIMIT  = 200;    // Per awaited event

   logic              ioclk;
   logic              ionreset;
   logic              csr_en;
   logic [CRDT_W-1:0] csr_crdt_req_init;
   logic [CRDT_W-1:0] csr_crdt_resp_init;
   logic              rx_valid;
   beat_t             rx_data;
   umi_pkt_t          req_pkt;
   umi_pkt_t          resp_pkt;
   logic              req_valid, req_ready;
   logic              resp_valid, resp_ready;
   logic [CRDT_W-1:0] loc_crdt_req, loc_crdt_resp;
   logic [CRDT_W-1:0] rmt_crdt_req, rmt_crdt_resp;

   int                seed      = 75520;
   int                err_value = 0;   // Wrong values seen
   int                err_other = 0;   // Missing or extra traffic
   int                cycles    = 0;
   int                exp_loc_req;
   int                exp_loc_resp;
   umi_pkt_t          got_req[$];      // Transfers seen on each port
   umi_pkt_t          got_resp[$];

   clink_rx_top #(.REQ_DEPTH(64), .RESP_DEPTH(64), .LINK_DEPTH(4)) dut_i (.*);

   //########################################
   // Clock, watchdog, port monitor
   //########################################
   initial
   begin
      ioclk = 1'b0;
      forever #10 ioclk = ~ioclk;
   end

   always @(posedge ioclk)
   begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   always @(posedge ioclk)
   begin
      if (req_valid && req_ready)
         got_req.push_back(req_pkt);
      if (resp_valid && resp_ready)
         got_resp.push_back(resp_pkt);
   end

   //########################################
   // Helpers
   //########################################
   // Beats on the pads for one command word
   function automatic int beat_count(input logic [31:0] cmd);
      int nbytes;
      int dbeats;
      nbytes = (int'(cmd[15:8]) + 1) << cmd[6:4];
      dbeats = (nbytes + 3) / 4;
      if (dbeats > 2)
         dbeats = 2;            // At most 8 data bytes
      case (cmd[3:0])
         OP_LINK:               return 1;
         OP_REQ_RD, OP_RESP_WR: return 3;
         OP_REQ_WR, OP_RESP_RD: return 3 + dbeats;
         default:               return 1;
      endcase
   endfunction

   function automatic beat_t beat_of(input umi_pkt_t pkt, input int idx);
      case (idx)
         0:       return pkt.cmd;
         1:       return pkt.dstaddr;
         2:       return pkt.srcaddr;
         3:       return pkt.data[31:0];
         default: return pkt.data[63:32];
      endcase
   endfunction

   function automatic umi_pkt_t make_pkt(input logic [3:0] opcode);
      umi_pkt_t    p;
      logic [31:0] r;
      r         = $random(seed);
      p.cmd     = {r[31:16], 8'h00, 1'b0, 3'd3, opcode};
      p.dstaddr = $random(seed);
      p.srcaddr = $random(seed);
      r         = $random(seed);
      p.data    = {r, 32'($random(seed))};
      if (beat_count(p.cmd) == 3)
         p.data = '0;           // No-data packet comes out zeroed
      return p;
   endfunction

   task automatic send_packet(input umi_pkt_t pkt);
      int i;
      for (i = 0; i < beat_count(pkt.cmd); i++)
      begin
         @(negedge ioclk);
         rx_valid = 1'b1;
         rx_data  = beat_of(pkt, i);
      end
      @(negedge ioclk);
      rx_valid = 1'b0;
      rx_data  = '0;
   endtask

   task automatic send_link(input logic [7:0] code, input logic [15:0] value);
      umi_pkt_t p;
      p     = '0;
      p.cmd = {value, code, 1'b0, 3'd0, OP_LINK};
      send_packet(p);
   endtask

   task automatic compare_field(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         err_value++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic expect_pkt(input bit on_resp, input umi_pkt_t exp);
      umi_pkt_t got;
      int       waited;
      string    port;
      port   = on_resp ? "resp_pkt" : "req_pkt";
      waited = 0;
      while (((on_resp ? got_resp.size() : got_req.size()) == 0) && (waited < WAIT_LIMIT))
      begin
         @(negedge ioclk);
         waited++;
      end
      assert (waited < WAIT_LIMIT)
      else
      begin
         err_other++;
         $display("No packet arrived on %s within %0d cycles", port, WAIT_LIMIT);
      end
      if (waited < WAIT_LIMIT)
      begin
         if (on_resp)
            got = got_resp.pop_front();
         else
            got = got_req.pop_front();
         compare_field({port, ".cmd"}, 64'(got.cmd), 64'(exp.cmd));
         compare_field({port, ".dstaddr"}, 64'(got.dstaddr), 64'(exp.dstaddr));
         compare_field({port, ".srcaddr"}, 64'(got.srcaddr), 64'(exp.srcaddr));
         compare_field({port, ".data"}, got.data, exp.data);
      end
   endtask

   // Nothing more may show up on either port
   task automatic expect_quiet(input int settle);
      repeat (settle) @(negedge ioclk);
      assert (got_req.size() == 0)
      else
      begin
         err_other++;
         $display("Unexpected extra packets on req_pkt: %0d", got_req.size());
      end
      assert (got_resp.size() == 0)
      else
      begin
         err_other++;
         $display("Unexpected extra packets on resp_pkt: %0d", got_resp.size());
      end
      got_req.delete();
      got_resp.delete();
   endtask

   task automatic wait_remote(input bit on_resp, input logic [15:0] value);
      int waited;
      waited = 0;
      while (((on_resp ? rmt_crdt_resp : rmt_crdt_req) != value) && (waited < WAIT_LIMIT))
      begin
         @(negedge ioclk);
         waited++;
      end
      compare_field(on_resp ? "rmt_crdt_resp" : "rmt_crdt_req",
                    64'(on_resp ? rmt_crdt_resp : rmt_crdt_req), 64'(value));
   endtask

   task automatic check_local(input string when);
      compare_field({"loc_crdt_req ", when}, 64'(loc_crdt_req), 64'(exp_loc_req));
      compare_field({"loc_crdt_resp ", when}, 64'(loc_crdt_resp), 64'(exp_loc_resp));
   endtask

   //########################################
   // Directed tests
   //########################################
   task automatic idle_after_reset();
      repeat (2) @(negedge ioclk);             // Init loads on first edge
      compare_field("req_valid after reset", 64'(req_valid), 64'(0));
      compare_field("resp_valid after reset", 64'(resp_valid), 64'(0));
      exp_loc_req  = int'(csr_crdt_req_init);
      exp_loc_resp = int'(csr_crdt_resp_init);
      check_local("while disabled");
      csr_en = 1'b1;
      repeat (10) @(negedge ioclk);
      check_local("after enable");
   endtask

   task automatic request_traffic();
      umi_pkt_t p;
      p = make_pkt(OP_REQ_WR);
      send_packet(p);
      exp_loc_req += beat_count(p.cmd);
      expect_pkt(1'b0, p);
      p = make_pkt(OP_REQ_RD);
      send_packet(p);
      exp_loc_req += beat_count(p.cmd);
      expect_pkt(1'b0, p);
      expect_quiet(10);
      check_local("after requests");
   endtask

   task automatic response_traffic();
      umi_pkt_t p;
      p = make_pkt(OP_RESP_RD);
      send_packet(p);
      exp_loc_resp += beat_count(p.cmd);
      expect_pkt(1'b1, p);
      p = make_pkt(OP_RESP_WR);
      send_packet(p);
      exp_loc_resp += beat_count(p.cmd);
      expect_pkt(1'b1, p);
      expect_quiet(10);
      check_local("after responses");
   endtask

   task automatic link_credit_capture();
      logic [31:0] r;
      logic [15:0] keep_req, keep_resp;
      r = $random(seed);
      send_link(CRDT_CODE_REQ, r[15:0]);
      wait_remote(1'b0, r[15:0]);
      send_link(CRDT_CODE_RESP, r[31:16]);
      wait_remote(1'b1, r[31:16]);
      keep_req  = rmt_crdt_req;
      keep_resp = rmt_crdt_resp;
      send_link(8'h05, ~r[15:0]);             // Unknown code
      repeat (10) @(negedge ioclk);            // Pulse would land within 5 cycles
      compare_field("rmt_crdt_req, other code", 64'(rmt_crdt_req), 64'(keep_req));
      compare_field("rmt_crdt_resp, other code", 64'(rmt_crdt_resp), 64'(keep_resp));
      expect_quiet(2);
      check_local("after link packets");
   endtask

   task automatic backpressure_order();
      umi_pkt_t   exp_req[$];
      umi_pkt_t   exp_resp[$];
      umi_pkt_t   p;
      logic [3:0] ops [4];
      int         i;
      int         waited;
      ops    = '{OP_REQ_WR, OP_RESP_RD, OP_REQ_RD, OP_RESP_WR};
      csr_en = 1'b0;                           // Reload local credits
      repeat (2) @(negedge ioclk);
      csr_en       = 1'b1;
      exp_loc_req  = int'(csr_crdt_req_init);
      exp_loc_resp = int'(csr_crdt_resp_init);
      req_ready    = 1'b0;
      resp_ready   = 1'b0;
      for (i = 0; i < 4; i++)
      begin
         p = make_pkt(ops[i]);
         send_packet(p);
         if ((ops[i] == OP_REQ_WR) || (ops[i] == OP_REQ_RD))
         begin
            exp_req.push_back(p);
            exp_loc_req += beat_count(p.cmd);
         end
         else
         begin
            exp_resp.push_back(p);
            exp_loc_resp += beat_count(p.cmd);
         end
      end
      waited = 0;
      while (!(req_valid && resp_valid) && (waited < WAIT_LIMIT))
      begin
         @(negedge ioclk);
         waited++;
      end
      assert (req_valid && resp_valid)
      else
      begin
         err_other++;
         $display("Output ports did not both fill while ready was held low");
      end
      repeat (4) @(negedge ioclk);             // Held packets must stay put
      req_ready  = 1'b1;
      resp_ready = 1'b1;
      while (exp_req.size() > 0)
         expect_pkt(1'b0, exp_req.pop_front());
      while (exp_resp.size() > 0)
         expect_pkt(1'b1, exp_resp.pop_front());
      expect_quiet(10);
      check_local("after back-pressure");
   endtask

   //########################################
   // Main sequence
   //########################################
   initial
   begin
      ionreset           = 1'b0;
      csr_en             = 1'b0;
      csr_crdt_req_init  = 16'h0100;
      csr_crdt_resp_init = 16'h0040;
      rx_valid           = 1'b0;
      rx_data            = '0;
      req_ready          = 1'b1;
      resp_ready         = 1'b1;
      repeat (8) @(negedge ioclk);
      ionreset = 1'b1;
      idle_after_reset();
      request_traffic();
      response_traffic();
      link_credit_capture();
      backpressure_order();
      $display("Errors: %0d wrong value, %0d missing or extra traffic",
               err_value, err_other);
      if ((err_value + err_other) == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- compile.f
clink_rx_pkg.sv
clink_rx_framer.sv
clink_rx_fifo.sv
clink_rx_assembler.sv
clink_rx_credits.sv
clink_rx_top.sv
clink_rx_properties.sv
tb_clink_rx.sv

//--- Makefile
# Verilator build and run of the receiver testbench
TOP = tb_clink_rx

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null

clean:
	rm -rf obj_dir
